// File: src.f
source/rvPkg.sv
source/alu.sv
source/immExtend.sv
source/registerFile.sv
source/programCounter.sv
source/controlUnit.sv
source/dataPath.sv
source/rvCore.sv
test/clockGen.sv
test/tbRvCore.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP       = tbRvCore
FILELIST  = src.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: test/rvCases.txt
// pc       instr    loadData we addr     wdata     one line per executed instruction
// addr and wdata are compared only on lines with we set, x1 = 5 and x2 = -3 throughout
00000000 00500093 00000000 0 00000000 00000000 // addi x1, x0, 5
00000004 ffd00113 00000000 0 00000000 00000000 // addi x2, x0, -3
00000008 002081b3 00000000 0 00000000 00000000 // add  x3, x1, x2
0000000c 40208233 00000000 0 00000000 00000000 // sub  x4, x1, x2
00000010 0041a823 00000000 1 00000012 00000008 // sw   x4, 16(x3)
00000014 001112b3 00000000 0 00000000 00000000 // sll  x5, x2, x1
00000018 00115333 00000000 0 00000000 00000000 // srl  x6, x2, x1
0000001c fe62a823 00000000 1 ffffff90 07ffffff // sw   x6, -16(x5)
00000020 401153b3 00000000 0 00000000 00000000 // sra  x7, x2, x1
00000024 00112433 00000000 0 00000000 00000000 // slt  x8, x2, x1
00000028 0083a823 00000000 1 0000000f 00000001 // sw   x8, 16(x7)
0000002c 001134b3 00000000 0 00000000 00000000 // sltu x9, x2, x1
00000030 0020c533 00000000 0 00000000 00000000 // xor  x10, x1, x2
00000034 04a4a023 00000000 1 00000040 fffffff8 // sw   x10, 64(x9)
00000038 0020e5b3 00000000 0 00000000 00000000 // or   x11, x1, x2
0000003c 0020f633 00000000 0 00000000 00000000 // and  x12, x1, x2
00000040 00b62823 00000000 1 00000015 fffffffd // sw   x11, 16(x12)
00000044 ffe12693 00000000 0 00000000 00000000 // slti  x13, x2, -2
00000048 fff13713 00000000 0 00000000 00000000 // sltiu x14, x2, -1
0000004c 00e6a823 00000000 1 00000011 00000001 // sw    x14, 16(x13)
00000050 0f00c793 00000000 0 00000000 00000000 // xori  x15, x1, 0xf0
00000054 0300e813 00000000 0 00000000 00000000 // ori   x16, x1, 0x30
00000058 0107a023 00000000 1 000000f5 00000035 // sw    x16, 0(x15)
0000005c 7f017893 00000000 0 00000000 00000000 // andi  x17, x2, 0x7f0
00000060 00409913 00000000 0 00000000 00000000 // slli  x18, x1, 4
00000064 ff28a823 00000000 1 000007e0 00000050 // sw    x18, -16(x17)
00000068 01c15993 00000000 0 00000000 00000000 // srli  x19, x2, 28
0000006c 40115a13 00000000 0 00000000 00000000 // srai  x20, x2, 1
00000070 0149a823 00000000 1 0000001f fffffffe // sw    x20, 16(x19)
00000074 00802a83 cafef00d 0 00000000 00000000 // lw    x21, 8(x0)
00000078 01502223 00000000 1 00000004 cafef00d // sw    x21, 4(x0)
0000007c 00700013 00000000 0 00000000 00000000 // addi  x0, x0, 7
00000080 00002423 00000000 1 00000008 00000000 // sw    x0, 8(x0)
00000084 00208463 00000000 0 00000000 00000000 // beq  x1, x2, +8 not taken
00000088 00108463 00000000 0 00000000 00000000 // beq  x1, x1, +8 taken
00000090 00109463 00000000 0 00000000 00000000 // bne  x1, x1, +8 not taken
00000094 00209463 00000000 0 00000000 00000000 // bne  x1, x2, +8 taken
0000009c 0020c463 00000000 0 00000000 00000000 // blt  x1, x2, +8 not taken
000000a0 00114463 00000000 0 00000000 00000000 // blt  x2, x1, +8 taken
000000a8 00115463 00000000 0 00000000 00000000 // bge  x2, x1, +8 not taken
000000ac 0020d463 00000000 0 00000000 00000000 // bge  x1, x2, +8 taken
000000b4 00116463 00000000 0 00000000 00000000 // bltu x2, x1, +8 not taken
000000b8 0020e463 00000000 0 00000000 00000000 // bltu x1, x2, +8 taken
000000c0 0020f463 00000000 0 00000000 00000000 // bgeu x1, x2, +8 not taken
000000c4 00117463 00000000 0 00000000 00000000 // bgeu x2, x1, +8 taken
000000cc 00102023 00000000 1 00000000 00000005 // sw   x1, 0(x0)

// File: test/tbRvCore.sv
module tbRvCore import rvPkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int fields      = 6;   // pc, instruction, load data, store enable, address, write data
    localparam int maxCases    = 64;
    localparam int resetCycles = 10;
    localparam int settleDelay = 49;  // one step short of the rising edge after a falling edge
    localparam logic [xlen-1:0] resetAddr = '0;

    logic            clk;
    logic            reset;
    logic [xlen-1:0] instrMemAddr;
    logic [xlen-1:0] instrCode;
    logic [xlen-1:0] dataAddr;
    logic [xlen-1:0] dataWData;
    logic            dataWe;
    logic [xlen-1:0] dataRData;

    logic [xlen-1:0] caseWords [fields*maxCases];
    int              numCases;
    int              cycleLimit;
    int              errors = 0;
    int              checks = 0;
    int              cycles = 0;

    clockGen u_clockGen (
        .clk (clk)
    );

    rvCore #(
        .resetAddr (resetAddr)
    ) u_rvCore (
        .clk          (clk),
        .reset        (reset),
        .instrMemAddr (instrMemAddr),
        .instrCode    (instrCode),
        .dataAddr     (dataAddr),
        .dataWData    (dataWData),
        .dataWe       (dataWe),
        .dataRData    (dataRData)
    );

    task automatic reportMismatch(input string name, input logic [xlen-1:0] expected,
                                  input logic [xlen-1:0] actual);
        errors++;
        $display("ERR time %0t signal %s expected %h actual %h", $time, name, expected, actual);
    endtask

    task automatic loadCases();
        for (int i = 0; i < fields*maxCases; i++) begin
            caseWords[i] = {i[xlen-2:0], 1'b1};  // odd words never match an aligned pc
        end
        $readmemh("test/rvCases.txt", caseWords);
        numCases = 0;
        while (numCases < maxCases && caseWords[fields*numCases][1:0] == 2'b00) begin
            numCases++;
        end
    endtask

    // ##################################################################
    // run limit
    // ##################################################################

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ##################################################################
    // stimulus and checks, both memories are modeled from the cases
    // ##################################################################

    initial begin
        int base;
        reset     = 1'b1;
        instrCode = '0;
        dataRData = '0;
        loadCases();
        cycleLimit = resetCycles + numCases + 20;
        if (numCases == 0) begin
            errors++;
            $display("no instruction lines were found in test/rvCases.txt");
        end

        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        checks += 2;
        if (instrMemAddr !== resetAddr) reportMismatch("instrMemAddr", resetAddr, instrMemAddr);
        if (dataWe !== 1'b0) reportMismatch("dataWe", '0, {31'b0, dataWe});
        reset = 1'b0;

        for (int i = 0; i < numCases; i++) begin
            base = fields * i;
            if (i > 0) begin
                @(negedge clk);
            end
            checks++;  // pc was updated by the previous rising edge
            if (instrMemAddr !== caseWords[base]) begin
                reportMismatch("instrMemAddr", caseWords[base], instrMemAddr);
            end
            instrCode = caseWords[base + 1];
            dataRData = caseWords[base + 2];
            #settleDelay;
            checks++;
            if (dataWe !== caseWords[base + 3][0]) begin
                reportMismatch("dataWe", {31'b0, caseWords[base + 3][0]}, {31'b0, dataWe});
            end
            if (caseWords[base + 3][0]) begin
                checks += 2;
                if (dataAddr !== caseWords[base + 4]) begin
                    reportMismatch("dataAddr", caseWords[base + 4], dataAddr);
                end
                if (dataWData !== caseWords[base + 5]) begin
                    reportMismatch("dataWData", caseWords[base + 5], dataWData);
                end
            end
        end

        @(negedge clk);
        instrCode = '0;
        $display("errors: %0d  checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: test/clockGen.sv
module clockGen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int halfPeriod = 50;  // 100 ns clock period

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

endmodule

// File: source/rvCore.sv
module rvCore import rvPkg::*; #(
    parameter logic [xlen-1:0] resetAddr = '0
) (
    input  logic            clk,
    input  logic            reset,
    // instruction fetch
    output logic [xlen-1:0] instrMemAddr,
    input  logic [xlen-1:0] instrCode,
    // data memory
    output logic [xlen-1:0] dataAddr,
    output logic [xlen-1:0] dataWData,
    output logic            dataWe,
    input  logic [xlen-1:0] dataRData
);
    logic  regFileWe;
    aluOpT aluControl;
    logic  aluSrcSel;
    logic  wbSrcSel;
    logic  branch;

    // ##################################################################
    // decoder and datapath
    // ##################################################################

    controlUnit u_controlUnit (
        .instrCode  (instrCode),
        .regFileWe  (regFileWe),
        .aluControl (aluControl),
        .aluSrcSel  (aluSrcSel),
        .wbSrcSel   (wbSrcSel),
        .branch     (branch),
        .dataWe     (dataWe)  // store enable goes straight to the memory port
    );

    dataPath #(
        .resetAddr (resetAddr)
    ) u_dataPath (
        .clk          (clk),
        .reset        (reset),
        .regFileWe    (regFileWe),
        .aluControl   (aluControl),
        .aluSrcSel    (aluSrcSel),
        .wbSrcSel     (wbSrcSel),
        .branch       (branch),
        .instrCode    (instrCode),
        .dataRData    (dataRData),
        .instrMemAddr (instrMemAddr),
        .dataAddr     (dataAddr),
        .dataWData    (dataWData)
    );

endmodule

// File: source/dataPath.sv
module dataPath import rvPkg::*; #(
    parameter logic [xlen-1:0] resetAddr = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            regFileWe,
    input  aluOpT           aluControl,
    input  logic            aluSrcSel,
    input  logic            wbSrcSel,
    input  logic            branch,
    input  logic [xlen-1:0] instrCode,
    input  logic [xlen-1:0] dataRData,
    output logic [xlen-1:0] instrMemAddr,
    output logic [xlen-1:0] dataAddr,
    output logic [xlen-1:0] dataWData
);
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     rData1;
    logic [xlen-1:0]     rData2;
    logic [xlen-1:0]     immExt;
    logic [xlen-1:0]     aluB;
    logic [xlen-1:0]     aluResult;
    logic [xlen-1:0]     wbData;
    logic                branchTaken;

    assign rs1 = instrCode[19:15];
    assign rs2 = instrCode[24:20];
    assign rd  = instrCode[11:7];

    assign aluB        = aluSrcSel ? immExt : rData2;      // operand mux
    assign wbData      = wbSrcSel ? dataRData : aluResult; // writeback mux
    assign branchTaken = branch & aluResult[0];

    assign dataAddr  = aluResult;
    assign dataWData = rData2;

    registerFile u_registerFile (
        .clk    (clk),
        .reset  (reset),
        .we     (regFileWe),
        .rAddr1 (rs1),
        .rAddr2 (rs2),
        .wAddr  (rd),
        .wData  (wbData),
        .rData1 (rData1),
        .rData2 (rData2)
    );

    alu u_alu (
        .aluControl (aluControl),
        .a          (rData1),
        .b          (aluB),
        .result     (aluResult)
    );

    immExtend u_immExtend (
        .instrCode (instrCode),
        .immExt    (immExt)
    );

    programCounter #(
        .resetAddr (resetAddr)
    ) u_programCounter (
        .clk         (clk),
        .reset       (reset),
        .branchTaken (branchTaken),
        .immExt      (immExt),
        .pc          (instrMemAddr)
    );

endmodule

// File: source/controlUnit.sv
module controlUnit import rvPkg::*; (
    input  logic [xlen-1:0] instrCode,
    output logic            regFileWe,
    output aluOpT           aluControl,
    output logic            aluSrcSel,
    output logic            wbSrcSel,
    output logic            branch,
    output logic            dataWe
);
    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b30;

    assign opcode    = opcodeT'(instrCode[6:0]);
    assign funct3    = instrCode[14:12];
    assign funct7b30 = instrCode[30];

    // alt selects sub over add and sra over srl
    function automatic aluOpT decodeAlu(input logic [2:0] f3, input logic alt);
        aluOpT op;
        case (f3)
            3'b000:  op = alt ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = alt ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    always_comb begin
        regFileWe  = 1'b0;
        aluControl = aluAdd;
        aluSrcSel  = 1'b0;
        wbSrcSel   = 1'b0;
        branch     = 1'b0;
        dataWe     = 1'b0;
        case (opcode)
            opR: begin
                regFileWe  = 1'b1;
                aluControl = decodeAlu(funct3, funct7b30);
            end
            opI: begin
                regFileWe  = 1'b1;
                aluSrcSel  = 1'b1;
                // bit 30 is part of the immediate except for the right shifts
                aluControl = decodeAlu(funct3, (funct3 == 3'b101) && funct7b30);
            end
            opL: begin
                regFileWe = 1'b1;
                aluSrcSel = 1'b1;  // address is rs1 plus offset
                wbSrcSel  = 1'b1;
            end
            opS: begin
                aluSrcSel = 1'b1;
                dataWe    = 1'b1;
            end
            opB: begin
                branch = 1'b1;
                case (funct3)
                    3'b000:  aluControl = aluBeq;
                    3'b001:  aluControl = aluBne;
                    3'b100:  aluControl = aluBlt;
                    3'b101:  aluControl = aluBge;
                    3'b110:  aluControl = aluBltu;
                    3'b111:  aluControl = aluBgeu;
                    default: branch     = 1'b0;  // reserved encodings fall through
                endcase
            end
            default: ;  // unknown opcode leaves every enable low
        endcase
    end

endmodule

// File: source/programCounter.sv
module programCounter import rvPkg::*; #(
    parameter logic [xlen-1:0] resetAddr = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            branchTaken,
    input  logic [xlen-1:0] immExt,
    output logic [xlen-1:0] pc
);
    logic [xlen-1:0] pcStep;
    logic [xlen-1:0] pcNext;

    assign pcStep = branchTaken ? immExt : xlen'(4);
    assign pcNext = pc + pcStep;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pc <= resetAddr;
        end else begin
            pc <= pcNext;
        end
    end

    // a taken branch whose offset is not a multiple of four would misalign the pc
    pcAligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    ) else $error("programCounter: misaligned pc %h", pc);

endmodule

// File: source/registerFile.sv
module registerFile import rvPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  logic [regAddrW-1:0] rAddr1,
    input  logic [regAddrW-1:0] rAddr2,
    input  logic [regAddrW-1:0] wAddr,
    input  logic [xlen-1:0]     wData,
    output logic [xlen-1:0]     rData1,
    output logic [xlen-1:0]     rData2
);
    logic [xlen-1:0] regs [2**regAddrW];

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;  // x0 is never written
        end
    end

    // reads are combinational so an instruction sees writes from the previous cycle
    // x0 reads zero because it is cleared on reset and skipped by the write
    assign rData1 = regs[rAddr1];
    assign rData2 = regs[rAddr2];

    x0ReadsZero: assert property (
        @(posedge clk) disable iff (reset)
        (rAddr1 == '0) |-> (rData1 == '0)
    ) else $error("registerFile: x0 read returned a nonzero value");

endmodule

// File: source/immExtend.sv
module immExtend import rvPkg::*; (
    input  logic [xlen-1:0] instrCode,
    output logic [xlen-1:0] immExt
);
    opcodeT     opcode;
    logic [2:0] funct3;

    assign opcode = opcodeT'(instrCode[6:0]);
    assign funct3 = instrCode[14:12];

    always_comb begin
        case (opcode)
            opL: begin
                immExt = {{20{instrCode[31]}}, instrCode[31:20]};
            end
            opI: begin
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    // shift amount only, the upper field carries funct7
                    immExt = {27'b0, instrCode[24:20]};
                end else begin
                    // sltiu compares against the sign-extended value too
                    immExt = {{20{instrCode[31]}}, instrCode[31:20]};
                end
            end
            opS: begin
                immExt = {{20{instrCode[31]}}, instrCode[31:25], instrCode[11:7]};
            end
            opB: begin
                immExt = {
                    {19{instrCode[31]}},
                    instrCode[31],
                    instrCode[7],
                    instrCode[30:25],
                    instrCode[11:8],
                    1'b0
                };  // halfword offset, bit 0 always clear
            end
            default: begin
                immExt = '0;  // R-type has no immediate
            end
        endcase
    end

endmodule

// File: source/alu.sv
module alu import rvPkg::*; (
    input  aluOpT           aluControl,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result
);
    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;
    logic       equal;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;
    assign equal      = a == b;

    // ##################################################################
    // operation select
    // ##################################################################

    always_comb begin
        case (aluControl)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluSll:  result = a << shamt;
            aluSrl:  result = a >> shamt;
            aluSra:  result = $signed(a) >>> shamt;
            aluSlt:  result = {{(xlen-1){1'b0}}, ltSigned};
            aluSltu: result = {{(xlen-1){1'b0}}, ltUnsigned};
            aluXor:  result = a ^ b;
            aluOr:   result = a | b;
            aluAnd:  result = a & b;
            // branch flags land in bit 0 where the datapath picks them up
            aluBeq:  result = {{(xlen-1){1'b0}}, equal};
            aluBne:  result = {{(xlen-1){1'b0}}, !equal};
            aluBlt:  result = {{(xlen-1){1'b0}}, ltSigned};
            aluBge:  result = {{(xlen-1){1'b0}}, !ltSigned};
            aluBltu: result = {{(xlen-1){1'b0}}, ltUnsigned};
            aluBgeu: result = {{(xlen-1){1'b0}}, !ltUnsigned};
            default: result = '0;
        endcase
    end

endmodule

// File: source/rvPkg.sv
package rvPkg;

    // ##################################################################
    // widths
    // ##################################################################

    localparam int xlen     = 32;  // data word and address width
    localparam int regAddrW = 5;   // register index width, 32 registers

    // ##################################################################
    // major opcodes of the supported RV32I subset
    // ##################################################################

    typedef enum logic [6:0] {
        opR = 7'b0110011,  // register-register arithmetic and logic
        opL = 7'b0000011,  // loads, only lw is used
        opS = 7'b0100011,  // stores, only sw is used
        opI = 7'b0010011,  // register-immediate arithmetic and logic
        opB = 7'b1100011   // conditional branches
    } opcodeT;

    // ##################################################################
    // ALU operations
    // ##################################################################

    // branch tests share the ALU and return a single flag bit in the result
    typedef enum logic [4:0] {
        aluAdd  = 5'd0,
        aluSub  = 5'd1,
        aluSll  = 5'd2,
        aluSrl  = 5'd3,
        aluSra  = 5'd4,
        aluSlt  = 5'd5,
        aluSltu = 5'd6,
        aluXor  = 5'd7,
        aluOr   = 5'd8,
        aluAnd  = 5'd9,
        aluBeq  = 5'd10,
        aluBne  = 5'd11,
        aluBlt  = 5'd12,
        aluBge  = 5'd13,
        aluBltu = 5'd14,
        aluBgeu = 5'd15
    } aluOpT;

endpackage
